/* include/dds_defines.svh */
`ifndef DDS_DEFINES_SVH
`define DDS_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// synthesizer widths
////////////////////////////////////////////////////////////////////////////

`define DDS_PHASE_W       32    // phase accumulator
`define DDS_SAMPLE_W      12    // signed output sample
`define DDS_INDEX_W       8     // sine table address, top accumulator bits

// carrier step per clock
`define DDS_BASE_INC      32'd258

////////////////////////////////////////////////////////////////////////////
// pseudo-random bit source
////////////////////////////////////////////////////////////////////////////

`define LFSR_W            5
`define LFSR_SEED         5'd1

// clocks between lfsr steps, short stand-in for the one second tick
`define LFSR_TICK_CYCLES  16

`endif

/* hw/dds_pkg.sv */
`include "dds_defines.svh"

package dds_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // types
   ////////////////////////////////////////////////////////////////////////////

   typedef logic signed [`DDS_SAMPLE_W-1:0] sample_t;

   // carrier shape, matches the 2-bit wave_select code
   typedef enum logic [1:0] {
      wave_sin    = 2'b00,
      wave_cos    = 2'b01,
      wave_saw    = 2'b10,
      wave_square = 2'b11
   } wave_sel_e;

   // modulation mode
   typedef enum logic [1:0] {
      mod_none = 2'b00,
      mod_ask  = 2'b01,
      mod_fsk  = 2'b10,
      mod_bpsk = 2'b11
   } mod_sel_e;

   ////////////////////////////////////////////////////////////////////////////
   // quarter-wave sine table
   ////////////////////////////////////////////////////////////////////////////

   // entry i = round(2047 * sin((i + 0.5) * 2pi / 256))
   // half-sample offset makes the mirror about index 64 exact
   localparam int unsigned QUARTER_LEN = 64;

   localparam logic [10:0] QUARTER_SINE [QUARTER_LEN] = '{
      11'd25,   11'd75,   11'd126,  11'd176,  11'd226,  11'd275,  11'd325,  11'd375,
      11'd424,  11'd473,  11'd522,  11'd570,  11'd618,  11'd666,  11'd713,  11'd760,
      11'd807,  11'd852,  11'd898,  11'd943,  11'd987,  11'd1031, 11'd1074, 11'd1116,
      11'd1158, 11'd1199, 11'd1239, 11'd1279, 11'd1318, 11'd1356, 11'd1393, 11'd1430,
      11'd1465, 11'd1500, 11'd1533, 11'd1566, 11'd1598, 11'd1629, 11'd1659, 11'd1688,
      11'd1716, 11'd1743, 11'd1769, 11'd1793, 11'd1817, 11'd1840, 11'd1861, 11'd1881,
      11'd1901, 11'd1919, 11'd1936, 11'd1951, 11'd1966, 11'd1979, 11'd1992, 11'd2003,
      11'd2012, 11'd2021, 11'd2028, 11'd2035, 11'd2039, 11'd2043, 11'd2046, 11'd2047
   };

   ////////////////////////////////////////////////////////////////////////////
   // full-wave lookup
   ////////////////////////////////////////////////////////////////////////////

   // quadrant from the top two index bits
   // odd quadrants read the table backwards, second half is negated
   function automatic sample_t sine_lookup(input logic [`DDS_INDEX_W-1:0] index);
      logic [1:0]                 quadrant;
      logic [`DDS_INDEX_W-3:0]    offset;
      logic [`DDS_INDEX_W-3:0]    addr;
      sample_t                    magnitude;
      quadrant  = index[`DDS_INDEX_W-1 -: 2];
      offset    = index[`DDS_INDEX_W-3:0];
      addr      = quadrant[0] ? ~offset : offset;   // 63 - offset when mirrored
      magnitude = sample_t'({1'b0, QUARTER_SINE[addr]});
      if (quadrant[1]) begin
         return -magnitude;
      end
      return magnitude;
   endfunction

endpackage

/* hw/dds_wave_if.sv */
`timescale 1ns/100ps

// five samples from the synthesizer to the mixer, all updated together
interface dds_wave_if;

   dds_pkg::sample_t sin_sample;
   dds_pkg::sample_t cos_sample;
   dds_pkg::sample_t saw_sample;
   dds_pkg::sample_t square_sample;
   dds_pkg::sample_t fsk_sample;   // sine at the fsk increment

   modport source (
      output sin_sample,
      output cos_sample,
      output saw_sample,
      output square_sample,
      output fsk_sample
   );

   modport sink (
      input sin_sample,
      input cos_sample,
      input saw_sample,
      input square_sample,
      input fsk_sample
   );

endinterface

/* hw/waveform_gen.sv */
`timescale 1ns/100ps
`include "dds_defines.svh"

module waveform_gen (
   input  logic                    CLK_25MHZ,
   input  logic                    reset_from_key,
   input  logic [`DDS_PHASE_W-1:0] fsk_phase_inc,
   dds_wave_if.source              wave
);

   localparam logic [`DDS_INDEX_W-1:0] QUARTER_TURN = `DDS_INDEX_W'(1 << (`DDS_INDEX_W - 2));
   localparam logic [`DDS_SAMPLE_W-1:0] FULL_SCALE = `DDS_SAMPLE_W'(2047);

   logic [`DDS_PHASE_W-1:0] carrier_acc;
   logic [`DDS_PHASE_W-1:0] fsk_acc;

   logic [`DDS_INDEX_W-1:0] carrier_index;
   logic [`DDS_INDEX_W-1:0] fsk_index;

   assign carrier_index = carrier_acc[`DDS_PHASE_W-1 -: `DDS_INDEX_W];
   assign fsk_index     = fsk_acc[`DDS_PHASE_W-1 -: `DDS_INDEX_W];

   ////////////////////////////////////////////////////////////////////////////
   // phase accumulators
   ////////////////////////////////////////////////////////////////////////////

   // separate fsk accumulator, nothing is fed back into the carrier
   always_ff @(posedge CLK_25MHZ) begin
      if (reset_from_key) begin
         carrier_acc <= '0;
         fsk_acc     <= '0;
      end else begin
         carrier_acc <= carrier_acc + `DDS_BASE_INC;
         fsk_acc     <= fsk_acc + fsk_phase_inc;   // wraps freely
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // sample registers
   ////////////////////////////////////////////////////////////////////////////

   // samples trail the accumulator by one clock
   always_ff @(posedge CLK_25MHZ) begin
      if (reset_from_key) begin
         wave.sin_sample    <= '0;
         wave.cos_sample    <= '0;
         wave.saw_sample    <= '0;
         wave.square_sample <= '0;
         wave.fsk_sample    <= '0;
      end else begin
         wave.sin_sample <= dds_pkg::sine_lookup(carrier_index);
         // cosine leads by a quarter turn
         wave.cos_sample <= dds_pkg::sine_lookup(carrier_index + QUARTER_TURN);

         // ramp is the raw top bits as two's complement
         wave.saw_sample <= dds_pkg::sample_t'(carrier_acc[`DDS_PHASE_W-1 -: `DDS_SAMPLE_W]);

         if (carrier_acc[`DDS_PHASE_W-1]) begin   // second half of the turn
            wave.square_sample <= -dds_pkg::sample_t'(FULL_SCALE);
         end else begin
            wave.square_sample <= dds_pkg::sample_t'(FULL_SCALE);
         end

         wave.fsk_sample <= dds_pkg::sine_lookup(fsk_index);
      end
   end

endmodule

/* hw/lfsr_pattern_gen.sv */
`timescale 1ns/100ps
`include "dds_defines.svh"

module lfsr_pattern_gen #(
   parameter int TICK_CYCLES = `LFSR_TICK_CYCLES
) (
   input  logic               CLK_25MHZ,
   input  logic               reset_from_key,
   output logic [`LFSR_W-1:0] lfsr_state,
   output logic               lfsr_bit,
   output logic               lfsr_step
);

   localparam int CNT_W = $clog2(TICK_CYCLES);

   logic [CNT_W-1:0] tick_cnt;
   logic             tick_last;

   assign tick_last = (tick_cnt == CNT_W'(TICK_CYCLES - 1));

   ////////////////////////////////////////////////////////////////////////////
   // tick divider and lfsr
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ) begin
      if (reset_from_key) begin
         tick_cnt   <= '0;
         lfsr_state <= `LFSR_SEED;
         lfsr_step  <= 1'b0;
      end else begin
         lfsr_step <= tick_last;   // high on the edge the state moves
         if (tick_last) begin
            tick_cnt <= '0;
            // x^5 + x^3 + 1, shifting toward bit 0
            lfsr_state <= {lfsr_state[0] ^ lfsr_state[2], lfsr_state[`LFSR_W-1:1]};
         end else begin
            tick_cnt <= tick_cnt + 1'b1;
         end
      end
   end

   // modulating bit
   assign lfsr_bit = lfsr_state[0];

endmodule

/* hw/modulation_mixer.sv */
`timescale 1ns/100ps

module modulation_mixer (
   input  logic                CLK_25MHZ,
   input  logic                reset_from_key,
   dds_wave_if.sink            wave,
   input  logic                lfsr_bit,
   input  dds_pkg::wave_sel_e  wave_select,
   input  dds_pkg::mod_sel_e   mod_select,
   output dds_pkg::sample_t    carrier_sample,
   output dds_pkg::sample_t    modulated_sample
);

   dds_pkg::sample_t carrier_next;
   dds_pkg::sample_t modulated_next;

   ////////////////////////////////////////////////////////////////////////////
   // carrier select
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      case (wave_select)
         dds_pkg::wave_sin:    carrier_next = wave.sin_sample;
         dds_pkg::wave_cos:    carrier_next = wave.cos_sample;
         dds_pkg::wave_saw:    carrier_next = wave.saw_sample;
         dds_pkg::wave_square: carrier_next = wave.square_sample;
         default:              carrier_next = wave.sin_sample;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // modulation
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      case (mod_select)
         dds_pkg::mod_none: begin
            modulated_next = wave.sin_sample;
         end
         dds_pkg::mod_ask: begin   // on-off keying
            modulated_next = lfsr_bit ? wave.sin_sample : '0;
         end
         dds_pkg::mod_fsk: begin
            modulated_next = lfsr_bit ? wave.fsk_sample : wave.sin_sample;
         end
         dds_pkg::mod_bpsk: begin
            // sine spans +-2047 so the negation cannot overflow
            modulated_next = lfsr_bit ? wave.sin_sample : -wave.sin_sample;
         end
         default: begin
            modulated_next = wave.sin_sample;
         end
      endcase
   end

   always_ff @(posedge CLK_25MHZ) begin
      if (reset_from_key) begin
         carrier_sample   <= '0;
         modulated_sample <= '0;
      end else begin
         carrier_sample   <= carrier_next;
         modulated_sample <= modulated_next;
      end
   end

endmodule

/* hw/dds_modulation_top.sv */
`timescale 1ns/100ps
`include "dds_defines.svh"

module dds_modulation_top (
   input  logic                     CLK_25MHZ,
   input  logic                     reset_from_key,
   input  logic [1:0]               wave_select,
   input  logic [1:0]               mod_select,
   input  logic [`DDS_PHASE_W-1:0]  fsk_phase_inc,
   output logic [`DDS_SAMPLE_W-1:0] carrier_sample,
   output logic [`DDS_SAMPLE_W-1:0] modulated_sample,
   output logic [`LFSR_W-1:0]       lfsr_state
);

   logic lfsr_bit;

   dds_wave_if wave_bus ();

   ////////////////////////////////////////////////////////////////////////////
   // signal sources
   ////////////////////////////////////////////////////////////////////////////

   waveform_gen i_waveform_gen (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .fsk_phase_inc  (fsk_phase_inc),
      .wave           (wave_bus.source)
   );

   // step pulse not needed here, the mixer samples the level
   lfsr_pattern_gen #(
      .TICK_CYCLES (`LFSR_TICK_CYCLES)
   ) i_lfsr_pattern_gen (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .lfsr_state     (lfsr_state),
      .lfsr_bit       (lfsr_bit),
      .lfsr_step      ()
   );

   ////////////////////////////////////////////////////////////////////////////
   // mixer
   ////////////////////////////////////////////////////////////////////////////

   modulation_mixer i_modulation_mixer (
      .CLK_25MHZ        (CLK_25MHZ),
      .reset_from_key   (reset_from_key),
      .wave             (wave_bus.sink),
      .lfsr_bit         (lfsr_bit),
      .wave_select      (dds_pkg::wave_sel_e'(wave_select)),   // raw codes to enums
      .mod_select       (dds_pkg::mod_sel_e'(mod_select)),
      .carrier_sample   (carrier_sample),
      .modulated_sample (modulated_sample)
   );

endmodule

/* tb/tb_dds_modulation.sv */
`timescale 1ns/100ps
`include "dds_defines.svh"

module tb_dds_modulation;

   localparam int CLK_PERIOD    = 40;   // 25 MHz
   localparam int RESET_CYCLES  = 8;
   localparam int SHAPE_CYCLES  = 300;  // per carrier shape
   localparam int MOD_CYCLES    = 160;  // ten lfsr ticks per mode
   localparam int RANDOM_CYCLES = 200;
   localparam int TOTAL_CYCLES  = RESET_CYCLES + 4 * SHAPE_CYCLES + 4 * MOD_CYCLES
                                  + RANDOM_CYCLES + 2;
   localparam int MARGIN_CYCLES = 100;
   localparam int LFSR_PERIOD   = 31;

   logic                     CLK_25MHZ = 1'b0;
   logic                     reset_from_key;
   logic [1:0]               wave_select;
   logic [1:0]               mod_select;
   logic [`DDS_PHASE_W-1:0]  fsk_phase_inc;
   logic [`DDS_SAMPLE_W-1:0] carrier_sample;
   logic [`DDS_SAMPLE_W-1:0] modulated_sample;
   logic [`LFSR_W-1:0]       lfsr_state;

   int    seed = 32'ha67c;
   string test_name;

   // edges since reset release, counted by the testbench itself
   int    edge_cnt = 0;
   logic  run_started = 1'b0;

   // selects in force at the edge being checked
   logic [1:0] prev_wave_sel = 2'd0;
   logic [1:0] prev_mod_sel  = 2'd0;
   string      prev_test     = "reset";

   int                      exp_carrier;
   int                      exp_modulated;
   int                      exp_lfsr;
   logic [`DDS_PHASE_W-1:0] model_acc;
   logic [`DDS_PHASE_W-1:0] model_fsk_acc;
   logic [`LFSR_W-1:0]      model_bit_state;

   dds_modulation_top i_dds_modulation_top (
      .CLK_25MHZ        (CLK_25MHZ),
      .reset_from_key   (reset_from_key),
      .wave_select      (wave_select),
      .mod_select       (mod_select),
      .fsk_phase_inc    (fsk_phase_inc),
      .carrier_sample   (carrier_sample),
      .modulated_sample (modulated_sample),
      .lfsr_state       (lfsr_state)
   );

   always #(CLK_PERIOD / 2) CLK_25MHZ = ~CLK_25MHZ;

   ////////////////////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////////////////////

   // lfsr state after edge k, one step every tick
   function automatic logic [`LFSR_W-1:0] lfsr_after_edges(input int k);
      logic [`LFSR_W-1:0] state;
      int                 steps;
      state = `LFSR_SEED;
      steps = k / `LFSR_TICK_CYCLES;
      for (int i = 0; i < steps; i++) begin
         state = {state[0] ^ state[2], state[`LFSR_W-1:1]};   // x^5 + x^3 + 1
      end
      return state;
   endfunction

   function automatic int ref_wave(input logic [1:0] sel, input logic [`DDS_PHASE_W-1:0] acc);
      logic [`DDS_INDEX_W-1:0] index;
      dds_pkg::sample_t        result;
      index = acc[`DDS_PHASE_W-1 -: `DDS_INDEX_W];
      case (dds_pkg::wave_sel_e'(sel))
         dds_pkg::wave_sin: result = dds_pkg::sine_lookup(index);
         dds_pkg::wave_cos: result = dds_pkg::sine_lookup(index + 8'd64);   // quarter turn
         dds_pkg::wave_saw: result = dds_pkg::sample_t'(acc[`DDS_PHASE_W-1 -: `DDS_SAMPLE_W]);
         default:           result = acc[`DDS_PHASE_W-1] ? dds_pkg::sample_t'(-2047)
                                                         : dds_pkg::sample_t'(2047);
      endcase
      return int'(result);
   endfunction

   function automatic int ref_modulated(input logic [1:0] mode, input logic data_bit,
                                        input logic [`DDS_PHASE_W-1:0] acc,
                                        input logic [`DDS_PHASE_W-1:0] fsk_acc);
      int sine;
      int fsk_sine;
      int result;
      sine     = int'(dds_pkg::sine_lookup(acc[`DDS_PHASE_W-1 -: `DDS_INDEX_W]));
      fsk_sine = int'(dds_pkg::sine_lookup(fsk_acc[`DDS_PHASE_W-1 -: `DDS_INDEX_W]));
      case (dds_pkg::mod_sel_e'(mode))
         dds_pkg::mod_none: result = sine;
         dds_pkg::mod_ask:  result = data_bit ? sine : 0;
         dds_pkg::mod_fsk:  result = data_bit ? fsk_sine : sine;
         default:           result = data_bit ? sine : -sine;   // bpsk
      endcase
      return result;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // comparison
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_value(input string test, input string signal_name,
                              input int expected, input logic signed [31:0] actual);
      assert (actual === expected) else begin
         $display("CHECK FAILED test=%s signal=%s expected=%0d actual=%0d",
                  test, signal_name, expected, actual);
         $display("Verification failed");
         $fatal(1, "mismatch on %s", signal_name);
      end
   endtask

   // reset_from_key is read before the stimulus updates it at this edge
   always @(posedge CLK_25MHZ) begin
      if (reset_from_key) begin
         edge_cnt    <= 0;
         run_started <= 1'b1;
      end else begin
         edge_cnt <= edge_cnt + 1;
      end
   end

   // outputs are settled at the falling edge
   always @(negedge CLK_25MHZ) begin
      if (run_started) begin
         exp_lfsr = int'(lfsr_after_edges(edge_cnt));
         if (edge_cnt < 2) begin   // pipeline still holds reset values
            exp_carrier   = 0;
            exp_modulated = 0;
         end else begin
            model_acc       = 32'(edge_cnt - 2) * `DDS_BASE_INC;
            model_fsk_acc   = 32'(edge_cnt - 2) * fsk_phase_inc;
            model_bit_state = lfsr_after_edges(edge_cnt - 1);   // bit before this edge
            exp_carrier     = ref_wave(prev_wave_sel, model_acc);
            exp_modulated   = ref_modulated(prev_mod_sel, model_bit_state[0],
                                            model_acc, model_fsk_acc);
         end
         // full period of the sequence brings back the seed
         if (edge_cnt == LFSR_PERIOD * `LFSR_TICK_CYCLES) begin
            check_value("lfsr period", "lfsr_state", `LFSR_SEED, lfsr_state);
         end
         check_value(prev_test, "carrier_sample", exp_carrier, $signed(carrier_sample));
         check_value(prev_test, "modulated_sample", exp_modulated, $signed(modulated_sample));
         check_value(prev_test, "lfsr_state", exp_lfsr, lfsr_state);
      end
      prev_wave_sel = wave_select;
      prev_mod_sel  = mod_select;
      prev_test     = test_name;
   end

   ////////////////////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////////////////////

   // called just after a rising edge, holds the selects for some cycles
   task automatic run_phase(input string name, input logic [1:0] wsel,
                            input logic [1:0] msel, input int cycles);
      test_name   <= name;
      wave_select <= wsel;
      mod_select  <= msel;
      repeat (cycles) @(posedge CLK_25MHZ);
   endtask

   task automatic run_random_selects(input int cycles);
      test_name <= "random selects";
      repeat (cycles) begin
         wave_select <= 2'($random(seed));
         mod_select  <= 2'($random(seed));
         @(posedge CLK_25MHZ);
      end
   endtask

   initial begin
      reset_from_key = 1'b1;
      wave_select    = 2'd0;
      mod_select     = 2'd0;
      fsk_phase_inc  = $random(seed);   // fixed for the whole run
      test_name      = "reset";

      repeat (RESET_CYCLES) @(posedge CLK_25MHZ);
      reset_from_key <= 1'b0;

      // carrier shapes
      run_phase("carrier sine", dds_pkg::wave_sin, dds_pkg::mod_none, SHAPE_CYCLES);
      run_phase("carrier cosine", dds_pkg::wave_cos, dds_pkg::mod_none, SHAPE_CYCLES);
      run_phase("carrier sawtooth", dds_pkg::wave_saw, dds_pkg::mod_none, SHAPE_CYCLES);
      run_phase("carrier square", dds_pkg::wave_square, dds_pkg::mod_none, SHAPE_CYCLES);

      // modulation modes, lfsr keeps running underneath
      run_phase("mod none", dds_pkg::wave_sin, dds_pkg::mod_none, MOD_CYCLES);
      run_phase("mod ask", dds_pkg::wave_sin, dds_pkg::mod_ask, MOD_CYCLES);
      run_phase("mod bpsk", dds_pkg::wave_sin, dds_pkg::mod_bpsk, MOD_CYCLES);
      run_phase("mod fsk", dds_pkg::wave_sin, dds_pkg::mod_fsk, MOD_CYCLES);

      run_random_selects(RANDOM_CYCLES);
      repeat (2) @(posedge CLK_25MHZ);

      $display("Verification passed");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // watchdog
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      #((TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
      $display("timeout: the stimulus did not finish within %0d clock cycles",
               TOTAL_CYCLES + MARGIN_CYCLES);
      $display("Verification failed");
      $fatal(1, "watchdog expired");
   end

endmodule

/* src.f */
+incdir+include
hw/dds_pkg.sv
hw/dds_wave_if.sv
hw/waveform_gen.sv
hw/lfsr_pattern_gen.sv
hw/modulation_mixer.sv
hw/dds_modulation_top.sv
tb/tb_dds_modulation.sv
